// ==== design/slide_pkg.sv ====
package slide_pkg;

  // Lane geometry
  localparam int unsigned NrLanes   = 4;
  localparam int unsigned LaneBytes = 8;
  localparam int unsigned BeatBytes = NrLanes * LaneBytes;

  // Instruction ids and queue depths
  localparam int unsigned NrVInsn          = 8;
  localparam int unsigned InsnQueueDepth   = 4;
  localparam int unsigned ResultQueueDepth = 2;

  // Pointer and counter widths
  localparam int unsigned InsnIdxW = $clog2(InsnQueueDepth);
  localparam int unsigned ResIdxW  = $clog2(ResultQueueDepth);
  // Byte pointer inside a beat, must also hold BeatBytes itself
  localparam int unsigned BytePntW = $clog2(BeatBytes) + 1;
  // 16-bit vl or offset scaled by up to 8 bytes per element
  localparam int unsigned ByteCntW = 16 + 3;

  typedef logic [InsnIdxW-1:0] insn_idx_t;
  typedef logic [InsnIdxW:0]   insn_cnt_t;
  typedef logic [ResIdxW-1:0]  res_idx_t;
  typedef logic [ResIdxW:0]    res_cnt_t;
  typedef logic [BytePntW-1:0] byte_pnt_t;
  typedef logic [ByteCntW-1:0] byte_cnt_t;

  typedef logic [15:0]                  vl_t;
  typedef logic [15:0]                  offset_t;
  typedef logic [9:0]                   vaddr_t;
  typedef logic [$clog2(NrVInsn)-1:0]   vid_t;

  // Element width, log2 of the bytes per element
  typedef enum logic [1:0] {EW8, EW16, EW32, EW64} sew_e;
  typedef enum logic {SLIDE_UP, SLIDE_DOWN} slide_op_e;

  typedef struct packed {
    vid_t      id;
    slide_op_e op;
    sew_e      sew;
    vl_t       vl;
    offset_t   offset;
    vaddr_t    vd;
  } slide_req_t;

  typedef logic [8*LaneBytes-1:0]  lane_word_t;
  typedef logic [LaneBytes-1:0]    lane_strb_t;
  // Byte b of a beat sits in lane b/8 at offset b mod 8
  typedef lane_word_t [NrLanes-1:0] beat_t;

  typedef struct packed {
    vid_t                     id;
    vaddr_t                   addr;
    beat_t                    wdata;
    lane_strb_t [NrLanes-1:0] be;
  } result_t;

  // Slide distance in bytes
  function automatic byte_cnt_t byte_offset(slide_req_t req);
    return byte_cnt_t'(req.offset) << req.sew;
  endfunction

  // Whole vector length in bytes
  function automatic byte_cnt_t total_bytes(slide_req_t req);
    return byte_cnt_t'(req.vl) << req.sew;
  endfunction

  // Bytes the unit writes back; slide-up skips the bytes under the offset
  function automatic byte_cnt_t written_bytes(slide_req_t req);
    if (req.op == SLIDE_UP) begin
      return total_bytes(req) - byte_offset(req);
    end
    return total_bytes(req);
  endfunction

endpackage

// ==== design/slide_if.sv ====
`timescale 1ns/100ps

// Head of the instruction queue toward the slide engine
interface slide_insn_if;

  logic                  valid;
  // One-cycle pulse pops the head from the issue side
  logic                  ready;
  slide_pkg::slide_req_t req;

  modport queue (
    output valid,
    output req,
    input  ready
  );

  modport engine (
    input  valid,
    input  req,
    output ready
  );

endinterface

// Result beats from the engine into the result queue
interface slide_beat_if;

  logic                valid;
  // Ready means the result queue is not full
  logic                ready;
  // Final beat of an instruction
  logic                last;
  slide_pkg::result_t  beat;

  modport src (
    output valid,
    output last,
    output beat,
    input  ready
  );

  modport dst (
    input  valid,
    input  last,
    input  beat,
    output ready
  );

endinterface

// ==== design/slide_insn_queue.sv ====
`timescale 1ns/100ps

module slide_insn_queue (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Sequencer side
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  slide_pkg::slide_req_t         req_i,
  // Head toward the engine
  slide_insn_if.queue                   issue,
  // Retire strobe from the result queue
  input  logic                          commit_i,
  input  logic                          commit_last_i,
  output logic [slide_pkg::NrVInsn-1:0] done_o
);

  //////////////////////////////
  // Queue storage and pointers
  //////////////////////////////

  // The counts tell which slots hold a payload
  slide_pkg::slide_req_t queue_q [slide_pkg::InsnQueueDepth];

  // One pointer per phase of an instruction
  slide_pkg::insn_idx_t accept_pnt_q;
  slide_pkg::insn_idx_t issue_pnt_q;
  slide_pkg::insn_idx_t commit_pnt_q;
  // Instructions waiting to issue and waiting for write-back
  slide_pkg::insn_cnt_t issue_cnt_q;
  slide_pkg::insn_cnt_t commit_cnt_q;

  // Holds off the sequencer for the first cycle out of reset
  logic ready_en_q;
  logic full;
  logic accept;
  logic retire;

  // An instruction leaves only once its last beat has committed
  assign full        = commit_cnt_q == slide_pkg::insn_cnt_t'(slide_pkg::InsnQueueDepth);
  assign req_ready_o = ready_en_q && !full;
  assign accept      = req_valid_i && req_ready_o;
  assign retire      = commit_i && commit_last_i;

  // Registered head shows an accepted request the next cycle
  assign issue.valid = issue_cnt_q != '0;
  assign issue.req   = queue_q[issue_pnt_q];

  always_ff @(posedge clk_i) begin
    if (accept) begin
      queue_q[accept_pnt_q] <= req_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_en_q   <= 1'b0;
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      done_o       <= '0;
    end else begin
      ready_en_q <= 1'b1;
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + slide_pkg::insn_idx_t'(1);
      end
      // Engine done with the head
      if (issue.ready) begin
        issue_pnt_q <= issue_pnt_q + slide_pkg::insn_idx_t'(1);
      end
      if (retire) begin
        commit_pnt_q <= commit_pnt_q + slide_pkg::insn_idx_t'(1);
      end
      issue_cnt_q  <= issue_cnt_q + slide_pkg::insn_cnt_t'(accept)
                      - slide_pkg::insn_cnt_t'(issue.ready);
      commit_cnt_q <= commit_cnt_q + slide_pkg::insn_cnt_t'(accept)
                      - slide_pkg::insn_cnt_t'(retire);
      // Done pulse for the oldest instruction in accept order
      done_o <= '0;
      if (retire) begin
        done_o[queue_q[commit_pnt_q].id] <= 1'b1;
      end
    end
  end

  // A new request never lands on a slot that still waits for its commit
  a_no_accept_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> accept_pnt_q != commit_pnt_q || commit_cnt_q == '0)
    else $error("instruction accepted into a full queue");

  // Last beat commits only for an instruction the engine already issued
  a_commit_after_issue: assert property (@(posedge clk_i) disable iff (!rst_ni)
    retire |-> commit_cnt_q != '0 && issue_cnt_q < commit_cnt_q)
    else $error("last beat committed for an instruction not yet issued");

endmodule

// ==== design/slide_engine.sv ====
`timescale 1ns/100ps

module slide_engine (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Head of the instruction queue
  slide_insn_if.engine     issue,
  // Source vector, one full beat at a time
  input  logic             operand_valid_i,
  output logic             operand_ready_o,
  input  slide_pkg::beat_t operand_i,
  // Result beats toward the result queue
  slide_beat_if.src        result
);

  typedef enum logic [1:0] {IDLE, RUN, FINISH} state_e;

  state_e state_q, state_d;

  // Byte pointers inside the current input and output beat
  slide_pkg::byte_pnt_t in_pnt_q, in_pnt_d;
  slide_pkg::byte_pnt_t out_pnt_q, out_pnt_d;
  // Bytes still to be written for this instruction
  slide_pkg::byte_cnt_t remaining_q, remaining_d;
  // Address of the next result beat
  slide_pkg::vaddr_t    addr_q, addr_d;

  // Result beat under construction
  slide_pkg::beat_t                               wdata_q;
  slide_pkg::lane_strb_t [slide_pkg::NrLanes-1:0] be_q, be_d;

  // Flat byte views of the beats
  logic [8*slide_pkg::BeatBytes-1:0] in_flat;
  logic [8*slide_pkg::BeatBytes-1:0] wdata_flat;
  logic [slide_pkg::BeatBytes-1:0]   be_flat;

  slide_pkg::byte_cnt_t boff;
  slide_pkg::byte_pnt_t in_room, out_room, cnt;
  slide_pkg::byte_pnt_t in_sum, out_sum;
  logic                 step;
  logic                 fin;

  assign boff    = slide_pkg::byte_offset(issue.req);
  assign in_flat = operand_i;

  //////////////////////////////
  // Step size
  //////////////////////////////

  always_comb begin
    in_room  = slide_pkg::byte_pnt_t'(slide_pkg::BeatBytes) - in_pnt_q;
    out_room = slide_pkg::byte_pnt_t'(slide_pkg::BeatBytes) - out_pnt_q;
    // Copy up to the nearer beat boundary
    cnt      = (in_room < out_room) ? in_room : out_room;
    // Tail of the instruction cuts the step short
    fin      = remaining_q <= slide_pkg::byte_cnt_t'(cnt);
    if (fin) begin
      cnt = slide_pkg::byte_pnt_t'(remaining_q);
    end
    in_sum  = in_pnt_q + cnt;
    out_sum = out_pnt_q + cnt;
  end

  // Moves only with an operand and room in the result queue
  assign step = state_q == RUN && operand_valid_i && result.ready;

  // Pop on input wrap and push on output wrap or at the end
  assign operand_ready_o = step && (in_sum == slide_pkg::byte_pnt_t'(slide_pkg::BeatBytes)
                                    || fin);
  assign result.valid    = step && (out_sum == slide_pkg::byte_pnt_t'(slide_pkg::BeatBytes)
                                    || fin);
  assign result.last     = step && fin;
  assign issue.ready     = state_q == FINISH;

  //////////////////////////////
  // Byte copy and FSM
  //////////////////////////////

  always_comb begin
    state_d     = state_q;
    in_pnt_d    = in_pnt_q;
    out_pnt_d   = out_pnt_q;
    remaining_d = remaining_q;
    addr_d      = addr_q;
    wdata_flat  = wdata_q;
    be_flat     = be_q;

    if (step) begin
      for (int b = 0; b < int'(slide_pkg::BeatBytes); b++) begin
        automatic int src = int'(in_pnt_q) + b;
        automatic int dst = int'(out_pnt_q) + b;
        if (b < int'(cnt)) begin
          wdata_flat[8*dst +: 8] = in_flat[8*src +: 8];
          be_flat[dst]           = 1'b1;
        end
      end
    end

    // Outgoing beat carries the bytes of this step too
    result.beat.id    = issue.req.id;
    result.beat.addr  = addr_q;
    result.beat.wdata = wdata_flat;
    result.beat.be    = be_flat;
    be_d              = be_flat;

    unique case (state_q)
      IDLE: begin
        if (issue.valid) begin
          state_d     = RUN;
          remaining_d = slide_pkg::written_bytes(issue.req);
          be_d        = '0;
          if (issue.req.op == slide_pkg::SLIDE_UP) begin
            // Source from its start and destination from the offset
            in_pnt_d  = '0;
            out_pnt_d = slide_pkg::byte_pnt_t'(boff % slide_pkg::BeatBytes);
            addr_d    = issue.req.vd + slide_pkg::vaddr_t'(boff / slide_pkg::BeatBytes);
          end else begin
            // Source from the offset and destination from its start
            in_pnt_d  = slide_pkg::byte_pnt_t'(boff % slide_pkg::BeatBytes);
            out_pnt_d = '0;
            addr_d    = issue.req.vd;
          end
        end
      end
      RUN: begin
        if (step) begin
          in_pnt_d    = in_sum;
          out_pnt_d   = out_sum;
          remaining_d = remaining_q - slide_pkg::byte_cnt_t'(cnt);
          if (operand_ready_o) begin
            in_pnt_d = '0;
          end
          // Start a fresh beat once this one is handed off
          if (result.valid) begin
            out_pnt_d = '0;
            be_d      = '0;
            addr_d    = addr_q + slide_pkg::vaddr_t'(1);
          end
          if (fin) begin
            state_d = FINISH;
          end
        end
      end
      FINISH: begin
        // Head pops this cycle
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    wdata_q <= wdata_flat;
    be_q    <= be_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      in_pnt_q    <= '0;
      out_pnt_q   <= '0;
      remaining_q <= '0;
      addr_q      <= '0;
    end else begin
      state_q     <= state_d;
      in_pnt_q    <= in_pnt_d;
      out_pnt_q   <= out_pnt_d;
      remaining_q <= remaining_d;
      addr_q      <= addr_d;
    end
  end

  // Byte pointers stay inside a beat while the copy runs
  a_pnt_in_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == RUN |-> in_pnt_q < slide_pkg::byte_pnt_t'(slide_pkg::BeatBytes)
      && out_pnt_q < slide_pkg::byte_pnt_t'(slide_pkg::BeatBytes))
    else $error("byte pointer ran past the end of a beat");

endmodule

// ==== design/slide_result_queue.sv ====
`timescale 1ns/100ps

module slide_result_queue (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  // Beats from the engine
  slide_beat_if.dst                                      result,
  // Lane write-back, one handshake per lane
  output logic                  [slide_pkg::NrLanes-1:0] result_valid_o,
  input  logic                  [slide_pkg::NrLanes-1:0] result_ready_i,
  output slide_pkg::vid_t       [slide_pkg::NrLanes-1:0] result_id_o,
  output slide_pkg::vaddr_t     [slide_pkg::NrLanes-1:0] result_addr_o,
  output slide_pkg::beat_t                               result_wdata_o,
  output slide_pkg::lane_strb_t [slide_pkg::NrLanes-1:0] result_be_o,
  // Retire strobe toward the instruction queue
  output logic                                           commit_o,
  output logic                                           commit_last_o
);

  // Entry payload and its last flag
  slide_pkg::result_t                       entry_q [slide_pkg::ResultQueueDepth];
  logic [slide_pkg::ResultQueueDepth-1:0]   last_q;
  // Lanes that still have to take their word
  logic [slide_pkg::ResultQueueDepth-1:0][slide_pkg::NrLanes-1:0] lane_valid_q;

  slide_pkg::res_idx_t wr_pnt_q;
  slide_pkg::res_idx_t rd_pnt_q;
  slide_pkg::res_cnt_t cnt_q;

  slide_pkg::result_t head;
  logic               push;

  assign result.ready = cnt_q != slide_pkg::res_cnt_t'(slide_pkg::ResultQueueDepth);
  assign push         = result.valid && result.ready;

  //////////////////////////////
  // Lane write-back
  //////////////////////////////

  assign head           = entry_q[rd_pnt_q];
  assign result_valid_o = lane_valid_q[rd_pnt_q];
  assign result_id_o    = {slide_pkg::NrLanes{head.id}};
  assign result_addr_o  = {slide_pkg::NrLanes{head.addr}};
  assign result_wdata_o = head.wdata;
  assign result_be_o    = head.be;

  // Head retires once every lane has taken its word
  assign commit_o      = cnt_q != '0 && lane_valid_q[rd_pnt_q] == '0;
  assign commit_last_o = commit_o && last_q[rd_pnt_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      entry_q[wr_pnt_q] <= result.beat;
      last_q[wr_pnt_q]  <= result.last;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lane_valid_q <= '0;
      wr_pnt_q     <= '0;
      rd_pnt_q     <= '0;
      cnt_q        <= '0;
    end else begin
      // Each lane drops its valid on its own handshake
      for (int l = 0; l < int'(slide_pkg::NrLanes); l++) begin
        if (result_valid_o[l] && result_ready_i[l]) begin
          lane_valid_q[rd_pnt_q][l] <= 1'b0;
        end
      end
      // Write slot differs from the head whenever a lane is busy
      if (push) begin
        lane_valid_q[wr_pnt_q] <= '1;
        wr_pnt_q               <= wr_pnt_q + slide_pkg::res_idx_t'(1);
      end
      if (commit_o) begin
        rd_pnt_q <= rd_pnt_q + slide_pkg::res_idx_t'(1);
      end
      cnt_q <= cnt_q + slide_pkg::res_cnt_t'(push) - slide_pkg::res_cnt_t'(commit_o);
    end
  end

  // A waiting lane keeps its word until it takes it
  for (genvar l = 0; l < int'(slide_pkg::NrLanes); l++) begin : gen_lane_check
    a_lane_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_valid_o[l] && !result_ready_i[l] |=>
        result_valid_o[l] && $stable(result_wdata_o[l]) && $stable(result_be_o[l])
        && $stable(result_addr_o[l]) && $stable(result_id_o[l]))
      else $error("lane %0d output changed before its handshake", l);
  end

endmodule

// ==== design/slide_top.sv ====
`timescale 1ns/100ps

module slide_top (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  // Requests from the sequencer
  input  logic                                           req_valid_i,
  output logic                                           req_ready_o,
  input  slide_pkg::slide_req_t                          req_i,
  // Source vector beats
  input  logic                                           operand_valid_i,
  output logic                                           operand_ready_o,
  input  slide_pkg::beat_t                               operand_i,
  // Per-lane result write-back
  output logic                  [slide_pkg::NrLanes-1:0] result_valid_o,
  input  logic                  [slide_pkg::NrLanes-1:0] result_ready_i,
  output slide_pkg::vid_t       [slide_pkg::NrLanes-1:0] result_id_o,
  output slide_pkg::vaddr_t     [slide_pkg::NrLanes-1:0] result_addr_o,
  output slide_pkg::beat_t                               result_wdata_o,
  output slide_pkg::lane_strb_t [slide_pkg::NrLanes-1:0] result_be_o,
  // One bit per instruction id
  output logic                  [slide_pkg::NrVInsn-1:0] done_o
);

  // Queue head to engine, engine to result queue
  slide_insn_if insn_if ();
  slide_beat_if beat_if ();

  // Retire strobe back to the instruction queue
  logic commit;
  logic commit_last;

  slide_insn_queue i_insn_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_i         (req_i),
    .issue         (insn_if.queue),
    .commit_i      (commit),
    .commit_last_i (commit_last),
    .done_o        (done_o)
  );

  slide_engine i_engine (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .issue           (insn_if.engine),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .operand_i       (operand_i),
    .result          (beat_if.src)
  );

  slide_result_queue i_result_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .result         (beat_if.dst),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_id_o    (result_id_o),
    .result_addr_o  (result_addr_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .commit_o       (commit),
    .commit_last_o  (commit_last)
  );

endmodule

// ==== verif/slide_tb_lane_sink.sv ====
`timescale 1ns/100ps

module slide_tb_lane_sink (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Chance in percent that the lane is ready in a cycle
  input  int                                  prob_i,
  // One lane of the result write-back
  input  logic                                valid_i,
  output logic                                ready_o,
  input  slide_pkg::vid_t                     id_i,
  input  slide_pkg::vaddr_t                   addr_i,
  input  slide_pkg::lane_word_t               wdata_i,
  input  slide_pkg::lane_strb_t               be_i,
  // Read port into the model register file
  input  slide_pkg::vaddr_t                   rd_addr_i,
  input  logic [2:0]                          rd_idx_i,
  output logic [7:0]                          rd_byte_o,
  output logic                                rd_written_o,
  // Words taken so far, per instruction id
  output logic [slide_pkg::NrVInsn-1:0][15:0] beat_cnt_o
);

  // Model register file of this lane, one word per beat address
  slide_pkg::lane_word_t mem [1024];
  // Bytes that were written at least once
  slide_pkg::lane_strb_t written [1024];

  // Ready changes a little after the edge, like any other input
  initial begin
    ready_o = 1'b0;
    forever begin
      @(posedge clk_i);
      #2;
      ready_o = rst_ni && (int'($urandom % 100) < prob_i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      written    <= '{default: '0};
      beat_cnt_o <= '0;
    end else if (valid_i && ready_o) begin
      // Log only the enabled bytes
      for (int j = 0; j < int'(slide_pkg::LaneBytes); j++) begin
        if (be_i[j]) begin
          mem[addr_i][8*j +: 8] <= wdata_i[8*j +: 8];
          written[addr_i][j]    <= 1'b1;
        end
      end
      beat_cnt_o[id_i] <= beat_cnt_o[id_i] + 16'd1;
    end
  end

  assign rd_byte_o    = mem[rd_addr_i][8*rd_idx_i +: 8];
  assign rd_written_o = written[rd_addr_i][rd_idx_i];

endmodule

// ==== verif/slide_tb.sv ====
`timescale 1ns/100ps

module slide_tb;

  localparam int Timeout = 2000;

  logic                                           clk_i = 1'b0;
  logic                                           rst_ni;
  logic                                           req_valid_i;
  logic                                           req_ready_o;
  slide_pkg::slide_req_t                          req_i;
  logic                                           operand_valid_i;
  logic                                           operand_ready_o;
  slide_pkg::beat_t                               operand_i;
  logic                  [slide_pkg::NrLanes-1:0] result_valid_o;
  logic                  [slide_pkg::NrLanes-1:0] result_ready_i;
  slide_pkg::vid_t       [slide_pkg::NrLanes-1:0] result_id_o;
  slide_pkg::vaddr_t     [slide_pkg::NrLanes-1:0] result_addr_o;
  slide_pkg::beat_t                               result_wdata_o;
  slide_pkg::lane_strb_t [slide_pkg::NrLanes-1:0] result_be_o;
  logic                  [slide_pkg::NrVInsn-1:0] done_o;

  // Shared read port into the lane models
  slide_pkg::vaddr_t                   rd_addr;
  logic [2:0]                          rd_idx;
  logic [7:0]                          rd_byte [slide_pkg::NrLanes];
  logic [slide_pkg::NrLanes-1:0]       rd_written;
  logic [slide_pkg::NrVInsn-1:0][15:0] lane_cnt [slide_pkg::NrLanes];

  // Accepted requests in accept order and by id
  slide_pkg::slide_req_t req_tab [slide_pkg::NrVInsn];
  slide_pkg::slide_req_t pend [256];
  slide_pkg::vid_t       done_ord [256];
  int                    exp_beats [slide_pkg::NrVInsn];
  int                    accept_cnt, done_cnt, pend_rd;
  int                    err_cnt, test_cnt, lane_prob, next_vd;
  bit                    gaps;
  slide_pkg::vid_t       next_id;

  always #20 clk_i = ~clk_i;

  slide_top DUT (.*);

  ////////////////////////////////
  // Reference rule
  ////////////////////////////////

  // Source byte i of an instruction
  function automatic logic [7:0] src_byte(int i, slide_pkg::vid_t id);
    return 8'(i * 7 + int'(id));
  endfunction

  // Checks byte p from vd against the slide rule
  function automatic bit byte_ok(slide_pkg::slide_req_t r, int p, logic [7:0] v);
    int boff = int'(r.offset) << int'(r.sew);
    int total = int'(r.vl) << int'(r.sew);
    if (p < 0 || p >= total) return 1'b0;
    if (r.op == slide_pkg::SLIDE_UP) return p >= boff && v == src_byte(p - boff, r.id);
    return v == src_byte(p + boff, r.id);
  endfunction

  function automatic bit lane_ok(int l, slide_pkg::vid_t id, slide_pkg::vaddr_t addr,
                                 slide_pkg::lane_word_t w, slide_pkg::lane_strb_t be);
    slide_pkg::slide_req_t r = req_tab[id];
    bit ok = 1'b1;
    for (int j = 0; j < 8; j++) begin
      if (be[j]) ok &= byte_ok(r, (int'(addr) - int'(r.vd)) * 32 + 8 * l + j, w[8*j +: 8]);
    end
    return ok;
  endfunction

  // First source beat, operand pops and result beats of a request
  task automatic beat_counts(slide_pkg::slide_req_t r, output int first, output int pops,
                             output int beats);
    int boff = int'(r.offset) << int'(r.sew);
    int total = int'(r.vl) << int'(r.sew);
    int w = (r.op == slide_pkg::SLIDE_UP) ? total - boff : total;
    first = (r.op == slide_pkg::SLIDE_UP) ? 0 : boff / 32;
    pops  = (r.op == slide_pkg::SLIDE_UP) ? (w + 31) / 32 : (boff % 32 + w + 31) / 32;
    beats = (r.op == slide_pkg::SLIDE_UP) ? (boff % 32 + w + 31) / 32 : (w + 31) / 32;
  endtask

  function automatic bit beats_ok(slide_pkg::vid_t id);
    for (int l = 0; l < int'(slide_pkg::NrLanes); l++) begin
      if (int'(lane_cnt[l][id]) != exp_beats[id]) return 1'b0;
    end
    return 1'b1;
  endfunction

  ////////////////////////////////
  // Lane sinks and checks
  ////////////////////////////////

  for (genvar l = 0; l < int'(slide_pkg::NrLanes); l++) begin : gen_lane
    slide_tb_lane_sink i_sink (
      .clk_i(clk_i), .rst_ni(rst_ni), .prob_i(lane_prob),
      .valid_i(result_valid_o[l]), .ready_o(result_ready_i[l]), .id_i(result_id_o[l]),
      .addr_i(result_addr_o[l]), .wdata_i(result_wdata_o[l]), .be_i(result_be_o[l]),
      .rd_addr_i(rd_addr), .rd_idx_i(rd_idx), .rd_byte_o(rd_byte[l]),
      .rd_written_o(rd_written[l]), .beat_cnt_o(lane_cnt[l])
    );
    a_lane_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_valid_o[l] && result_ready_i[l] |->
        lane_ok(l, result_id_o[l], result_addr_o[l], result_wdata_o[l], result_be_o[l]))
      else begin
        err_cnt++;
        $display("ERROR %0t: lane %0d wrote a wrong or misplaced byte", $time, l);
      end
    a_lane_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_valid_o[l] && !result_ready_i[l] |=> result_valid_o[l]
        && $stable(result_wdata_o[l]) && $stable(result_be_o[l]) && $stable(result_addr_o[l]))
      else begin
        err_cnt++;
        $display("ERROR %0t: lane %0d changed before its ready", $time, l);
      end
  end

  a_reset_quiet: assert property (@(posedge clk_i) !rst_ni || $rose(rst_ni) |->
    !req_ready_o && !operand_ready_o && result_valid_o == '0 && done_o == '0)
    else begin
      err_cnt++;
      $display("ERROR %0t: output high during or right after reset", $time);
    end

  // A retiring id frees its slot a cycle before its done pulse
  a_queue_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept_cnt - done_cnt - $countones(done_o) >= 4 |-> !req_ready_o)
    else begin
      err_cnt++;
      $display("ERROR %0t: request ready with four instructions outstanding", $time);
    end

  a_done_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o != '0 |-> done_cnt < accept_cnt
      && int'(done_o) == 1 << int'(done_ord[done_cnt]) && beats_ok(done_ord[done_cnt]))
    else begin
      err_cnt++;
      $display("ERROR %0t: done pulse out of order or before all beats", $time);
    end

  always @(posedge clk_i) begin
    if (rst_ni && done_o != '0) done_cnt <= done_cnt + $countones(done_o);
  end

  ////////////////////////////////
  // Stimulus
  ////////////////////////////////

  task automatic abort(string what);
    $display("Timeout: no %s within %0d cycles", what, Timeout);
    $display("Test failed");
    $finish;
  endtask

  function automatic slide_pkg::slide_req_t make_req(slide_pkg::slide_op_e op, int sew,
                                                     int vl, int offset);
    slide_pkg::slide_req_t r;
    r.id     = next_id;
    r.op     = op;
    r.sew    = slide_pkg::sew_e'(sew);
    r.vl     = 16'(vl);
    r.offset = 16'(offset);
    r.vd     = slide_pkg::vaddr_t'(next_vd);
    next_id  = slide_pkg::vid_t'(next_id + 1);
    next_vd += 16;
    return r;
  endfunction

  task automatic send_req(slide_pkg::slide_req_t r);
    int  first, pops, beats;
    int  t = 0;
    bit  hs = 1'b0;
    beat_counts(r, first, pops, beats);
    req_i       = r;
    req_valid_i = 1'b1;
    while (!hs) begin
      @(negedge clk_i);
      hs = req_ready_o;
      @(posedge clk_i);
      #2;
      t++;
      if (t > Timeout) abort("request accept");
    end
    req_valid_i            = 1'b0;
    req_tab[r.id]          = r;
    pend[accept_cnt]       = r;
    done_ord[accept_cnt]   = r.id;
    exp_beats[r.id]       += beats;
    accept_cnt++;
  endtask

  // Streams the source beats of the oldest unfed request
  task automatic feed_next();
    slide_pkg::slide_req_t r;
    int first, pops, beats;
    int t = 0;
    bit hs;
    while (pend_rd >= accept_cnt) begin
      @(posedge clk_i);
      #2;
      t++;
      if (t > Timeout) abort("request to feed");
    end
    r = pend[pend_rd];
    pend_rd++;
    beat_counts(r, first, pops, beats);
    for (int k = 0; k < pops; k++) begin
      for (int b = 0; b < 32; b++) begin
        operand_i[b/8][8*(b%8) +: 8] = src_byte((first + k) * 32 + b, r.id);
      end
      hs = 1'b0;
      t  = 0;
      while (!hs) begin
        operand_valid_i = !gaps || ($urandom % 4 != 0);
        @(negedge clk_i);
        hs = operand_valid_i && operand_ready_o;
        @(posedge clk_i);
        #2;
        t++;
        if (t > Timeout) abort("operand pop");
      end
    end
    operand_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    int t = 0;
    while (done_cnt != accept_cnt) begin
      @(posedge clk_i);
      t++;
      if (t > Timeout) abort("done pulse");
    end
  endtask

  // Every byte in the written range must sit in the lane models
  task automatic check_regfile(slide_pkg::slide_req_t r);
    int boff = int'(r.offset) << int'(r.sew);
    int total = int'(r.vl) << int'(r.sew);
    int lane;
    for (int p = (r.op == slide_pkg::SLIDE_UP) ? boff : 0; p < total; p++) begin
      rd_addr = r.vd + slide_pkg::vaddr_t'(p / 32);
      rd_idx  = 3'(p % 8);
      lane    = (p % 32) / 8;
      #1;
      assert (rd_written[lane] && byte_ok(r, p, rd_byte[lane]))
        else begin
          err_cnt++;
          $display("ERROR %0t: byte %0d of id %0d missing or wrong", $time, p, r.id);
        end
    end
  endtask

  task automatic run_one(slide_pkg::slide_op_e op, int sew, int vl, int offset);
    slide_pkg::slide_req_t r = make_req(op, sew, vl, offset);
    fork
      send_req(r);
      feed_next();
    join
    wait_idle();
    check_regfile(r);
    @(posedge clk_i);
    #2;
  endtask

  // Five requests with the lanes held off until the queue fills
  task automatic back_to_back();
    slide_pkg::slide_req_t r [5];
    int t = 0;
    for (int i = 0; i < 5; i++) begin
      r[i] = make_req(i % 2 ? slide_pkg::SLIDE_DOWN : slide_pkg::SLIDE_UP, i % 4, 40, 3 + i);
    end
    lane_prob = 0;
    fork
      for (int i = 0; i < 5; i++) send_req(r[i]);
      for (int i = 0; i < 5; i++) feed_next();
      begin
        while (!(accept_cnt - done_cnt == 4 && !req_ready_o)) begin
          @(negedge clk_i);
          t++;
          if (t > Timeout) abort("full instruction queue");
        end
        lane_prob = 70;
      end
    join
    wait_idle();
    for (int i = 0; i < 5; i++) check_regfile(r[i]);
    @(posedge clk_i);
    #2;
  endtask

  task automatic report(string name, int err_before);
    test_cnt++;
    $display("%s: %s", name, (err_cnt == err_before) ? "ok" : "errors");
  endtask

  initial begin
    int e;
    void'($urandom(32'h1308410b));
    rst_ni          = 1'b1;
    req_valid_i     = 1'b0;
    req_i           = '0;
    operand_valid_i = 1'b0;
    operand_i       = '0;
    rd_addr         = '0;
    rd_idx          = '0;
    next_id         = '0;
    lane_prob       = 100;
    gaps            = 1'b0;
    #1 rst_ni = 1'b0;
    repeat (8) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    @(posedge clk_i);
    #2;
    report("reset outputs", 0);
    e = err_cnt;
    for (int s = 0; s < 4; s++) begin
      run_one(slide_pkg::SLIDE_UP, s, 96 >> s, 32 >> s);
      run_one(slide_pkg::SLIDE_UP, s, 96 >> s, 3);
    end
    report("slide up per sew", e);
    e = err_cnt;
    for (int s = 0; s < 4; s++) run_one(slide_pkg::SLIDE_DOWN, s, 96 >> s, 5);
    report("slide down per sew", e);
    // Random lane ready and operand gaps
    e         = err_cnt;
    gaps      = 1'b1;
    lane_prob = 50;
    for (int i = 0; i < 6; i++) begin
      int vl;
      vl = 8 + int'($urandom % 40);
      run_one(slide_pkg::slide_op_e'($urandom % 2), int'($urandom % 4), vl,
              int'($urandom % vl));
    end
    report("random back-pressure", e);
    e = err_cnt;
    back_to_back();
    report("back-to-back requests", e);
    $display("%0d tests, %0d errors", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
design/slide_pkg.sv
design/slide_if.sv
design/slide_insn_queue.sv
design/slide_engine.sv
design/slide_result_queue.sv
design/slide_top.sv
verif/slide_tb_lane_sink.sv
verif/slide_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the slide unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module slide_tb -f compile.f -o slide_sim

out=$(./obj_dir/slide_sim)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1
